// File: all.f
+incdir+rtl
rtl/center_sort_pkg.sv
rtl/center_node.sv
rtl/sort_sequencer.sv
rtl/result_drain.sv
rtl/center_sorter.sv
verification/center_sorter_tb.sv

// File: rtl/center_node.sv
`timescale 1ns/1ps
`default_nettype none

`include "center_sort_macros.svh"

module center_node #(
	parameter int node_index = 0
) (
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire logic                     shift,
	input  wire logic                     exchange,
	input  wire logic                     phase,
	input  wire center_sort_pkg::axis_t   axis,
	input  wire center_sort_pkg::center_t left_center,
	input  wire center_sort_pkg::center_t right_center,
	input  wire logic                     swap_from_left,
	output center_sort_pkg::center_t      center,
	output logic                          swap_to_right
);

	// parity of this cell picks the phases where it leads a pair
	localparam logic parity  = 1'(node_index % 2);
	localparam bit   is_last = (node_index == `NODE_COUNT - 1);

	logic                      is_lower;
	center_sort_pkg::coord_t   own_key;
	center_sort_pkg::coord_t   right_key;

	// coordinate of a center along the sort axis
	function automatic center_sort_pkg::coord_t key_of(
		input center_sort_pkg::center_t c,
		input center_sort_pkg::axis_t   a
	);
		return c[a*`COORD_WIDTH +: `COORD_WIDTH];
	endfunction

	// the last cell has no right neighbour, so it never leads a pair
	assign is_lower = exchange && (phase == parity) && !is_last;

	assign own_key   = key_of(center, axis);
	assign right_key = key_of(right_center, axis);

	// strict compare keeps equal keys in place
	// larger keys move toward node 0
	assign swap_to_right = is_lower && (own_key < right_key);

	always_ff @(posedge clk) begin
		if (reset) begin
			center <= '0;
		end else if (shift) begin
			center <= left_center;
		end else if (swap_to_right) begin
			center <= right_center;
		end else if (swap_from_left) begin
			// upper cell of a pair, the lower cell made the decision
			center <= left_center;
		end
	end

endmodule

`default_nettype wire

// File: rtl/center_sort_macros.svh
`ifndef CENTER_SORT_MACROS_SVH
`define CENTER_SORT_MACROS_SVH

// width of one coordinate of a center
`define COORD_WIDTH 8

// coordinates per center, coordinate 0 in the low bits
`define DIM 3

// cells in the sorting chain
// the sort finishes in this many exchange phases
`define NODE_COUNT 8

`endif

// File: rtl/center_sort_pkg.sv
`default_nettype none

`include "center_sort_macros.svh"

package center_sort_pkg;

	// one coordinate value
	typedef logic [`COORD_WIDTH-1:0] coord_t;

	// full center, coordinate 2 in the high byte
	typedef logic [`DIM*`COORD_WIDTH-1:0] center_t;

	// selected sort axis, 3 is not a legal axis
	typedef logic [1:0] axis_t;

	// host command strobed with cmd_valid
	typedef enum logic [1:0] {
		cmd_nop      = 2'd0,
		cmd_load     = 2'd1,
		cmd_sort     = 2'd2,
		cmd_reserved = 2'd3
	} host_cmd_t;

	// sequencer FSM
	typedef enum logic [1:0] {
		st_idle     = 2'd0,
		st_exchange = 2'd1,
		st_drain    = 2'd2
	} seq_state_t;

endpackage

`default_nettype wire

// File: rtl/center_sorter.sv
`timescale 1ns/1ps
`default_nettype none

`include "center_sort_macros.svh"

module center_sorter (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  wire logic                       cmd_valid,
	input  wire center_sort_pkg::host_cmd_t cmd,
	input  wire center_sort_pkg::center_t   center_in,
	input  wire center_sort_pkg::axis_t     axis_in,
	output logic                            busy,
	output center_sort_pkg::center_t        center_out,
	output logic                            center_out_valid,
	output logic                            done
);

	// chain[0] is the fill value, chain[i+1] is held by node i
	// chain[NODE_COUNT+1] stands in for the missing right neighbour of the last node
	center_sort_pkg::center_t chain [0:`NODE_COUNT+1];
	logic                     swap_link [0:`NODE_COUNT-1];

	logic                     shift;
	logic                     exchange;
	logic                     phase;
	center_sort_pkg::axis_t   axis;
	logic                     drain_done;
	logic                     drain_shift;

	assign chain[`NODE_COUNT+1] = '0;
	assign swap_link[0]         = 1'b0;

	// loads also shift, but only drain shifts carry results out
	assign drain_shift = shift && busy;

	sort_sequencer sort_sequencer_inst (
		.clk         (clk),
		.reset       (reset),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.center_in   (center_in),
		.axis_in     (axis_in),
		.drain_done  (drain_done),
		.fill_center (chain[0]),
		.shift       (shift),
		.exchange    (exchange),
		.phase       (phase),
		.axis        (axis),
		.busy        (busy)
	);

	genvar i;
	generate
		for (i = 0; i < `NODE_COUNT; i++) begin : g_node
			if (i < `NODE_COUNT - 1) begin : g_inner
				center_node #(.node_index(i)) center_node_inst (
					.clk            (clk),
					.reset          (reset),
					.shift          (shift),
					.exchange       (exchange),
					.phase          (phase),
					.axis           (axis),
					.left_center    (chain[i]),
					.right_center   (chain[i+2]),
					.swap_from_left (swap_link[i]),
					.center         (chain[i+1]),
					.swap_to_right  (swap_link[i+1])
				);
			end else begin : g_last
				// never the lower cell of a pair
				center_node #(.node_index(i)) center_node_inst (
					.clk            (clk),
					.reset          (reset),
					.shift          (shift),
					.exchange       (exchange),
					.phase          (phase),
					.axis           (axis),
					.left_center    (chain[i]),
					.right_center   (chain[i+2]),
					.swap_from_left (swap_link[i]),
					.center         (chain[i+1]),
					.swap_to_right  ()
				);
			end
		end
	endgenerate

	result_drain result_drain_inst (
		.clk              (clk),
		.reset            (reset),
		.shift            (drain_shift),
		.last_center      (chain[`NODE_COUNT]),
		.center_out       (center_out),
		.center_out_valid (center_out_valid),
		.done             (done),
		.drain_done       (drain_done)
	);

endmodule

`default_nettype wire

// File: rtl/result_drain.sv
`timescale 1ns/1ps
`default_nettype none

`include "center_sort_macros.svh"

module result_drain (
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire logic                     shift,
	input  wire center_sort_pkg::center_t last_center,
	output center_sort_pkg::center_t      center_out,
	output logic                          center_out_valid,
	output logic                          done,
	output logic                          drain_done
);

	localparam int cnt_w = $clog2(`NODE_COUNT);
	localparam logic [cnt_w-1:0] last_count = cnt_w'(`NODE_COUNT - 1);

	// centers taken so far in this drain
	logic [cnt_w-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			center_out       <= '0;
			center_out_valid <= 1'b0;
			done             <= 1'b0;
			count            <= '0;
		end else begin
			center_out_valid <= shift;
			// done lines up with the last valid result
			done <= shift && (count == last_count);
			if (shift) begin
				center_out <= last_center;
				if (count == last_count) begin
					count <= '0;
				end else begin
					count <= count + 1'b1;
				end
			end
		end
	end

	// the sequencer leaves the drain state on the same pulse
	assign drain_done = done;

endmodule

`default_nettype wire

// File: rtl/sort_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "center_sort_macros.svh"

module sort_sequencer (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  wire logic                       cmd_valid,
	input  wire center_sort_pkg::host_cmd_t cmd,
	input  wire center_sort_pkg::center_t   center_in,
	input  wire center_sort_pkg::axis_t     axis_in,
	input  wire logic                       drain_done,
	output center_sort_pkg::center_t        fill_center,
	output logic                            shift,
	output logic                            exchange,
	output logic                            phase,
	output center_sort_pkg::axis_t          axis,
	output logic                            busy
);

	// counter must reach NODE_COUNT during the drain wait
	localparam int cnt_w = $clog2(`NODE_COUNT + 1);
	localparam logic [cnt_w-1:0] last_phase = cnt_w'(`NODE_COUNT - 1);
	localparam logic [cnt_w-1:0] drain_len  = cnt_w'(`NODE_COUNT);

	center_sort_pkg::seq_state_t state;
	logic [cnt_w-1:0]            count;
	logic                        ready;
	logic                        load_go;
	logic                        sort_go;
	logic                        drain_shift;

	// the cycle that delivers the last result already counts as idle
	assign ready = (state == center_sort_pkg::st_idle) ||
		((state == center_sort_pkg::st_drain) && drain_done);

	assign load_go = ready && cmd_valid && (cmd == center_sort_pkg::cmd_load);

	// axis 3 does not exist, such a sort is dropped
	assign sort_go = ready && cmd_valid && (cmd == center_sort_pkg::cmd_sort) &&
		(axis_in != 2'd3);

	// drain shifts stop once NODE_COUNT centers have left
	assign drain_shift = (state == center_sort_pkg::st_drain) && (count != drain_len);

	assign shift       = load_go || drain_shift;
	assign fill_center = drain_shift ? '0 : center_in;
	assign exchange    = (state == center_sort_pkg::st_exchange);
	assign phase       = count[0];
	assign busy        = !ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= center_sort_pkg::st_idle;
			count <= '0;
			axis  <= '0;
		end else if (sort_go) begin
			state <= center_sort_pkg::st_exchange;
			count <= '0;
			axis  <= axis_in;
		end else begin
			case (state)
				center_sort_pkg::st_idle: begin
					count <= '0;
				end
				center_sort_pkg::st_exchange: begin
					// one odd-even phase per cycle
					if (count == last_phase) begin
						state <= center_sort_pkg::st_drain;
						count <= '0;
					end else begin
						count <= count + 1'b1;
					end
				end
				center_sort_pkg::st_drain: begin
					if (drain_done) begin
						state <= center_sort_pkg::st_idle;
						count <= '0;
					end else if (drain_shift) begin
						count <= count + 1'b1;
					end
				end
				default: begin
					state <= center_sort_pkg::st_idle;
					count <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verification/center_sorter_golden.txt
# columns: L <count> <centers to load>, S <axis> <test name>, E <count> <expected centers>
# centers are 24-bit hex, coordinate 2 in the high byte, coordinate 0 in the low byte

# test 1: sort of the empty chain after reset
S 0 empty_chain
E 8 000000 000000 000000 000000 000000 000000 000000 000000

# test 2: eight distinct centers on axis 0
L 8 30815c 9e0712 44d2a7 053b21 c166f0 7a1d08 59a493 e84f6d
S 0 distinct_axis0
E 8 7a1d08 9e0712 053b21 30815c e84f6d 59a493 44d2a7 c166f0

# test 3: the same centers on axis 1, then on axis 2
L 8 30815c 9e0712 44d2a7 053b21 c166f0 7a1d08 59a493 e84f6d
S 1 distinct_axis1
E 8 9e0712 7a1d08 053b21 e84f6d c166f0 30815c 59a493 44d2a7
L 8 30815c 9e0712 44d2a7 053b21 c166f0 7a1d08 59a493 e84f6d
S 2 distinct_axis2
E 8 053b21 30815c 44d2a7 59a493 7a1d08 9e0712 c166f0 e84f6d

# test 4: equal keys on axis 1 leave in load order
L 8 114001 222002 334003 442004 559005 664006 772007 884008
S 1 equal_keys
E 8 222002 442004 772007 114001 334003 664006 884008 559005

# test 5: three centers, the rest of the chain stays zero
L 3 a00102 2b0f3c 61e4d8
S 2 partial_load
E 8 000000 000000 000000 000000 000000 2b0f3c 61e4d8 a00102

# test 6: axis 3 is dropped and the loaded centers wait for a legal sort
L 8 e84f6d 59a493 7a1d08 c166f0 053b21 44d2a7 9e0712 30815c
S 3 bad_axis
S 0 after_bad_axis
E 8 7a1d08 9e0712 053b21 30815c e84f6d 59a493 44d2a7 c166f0

// File: verification/center_sorter_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "center_sort_macros.svh"

module center_sorter_tb;

	// six tests of about 40 cycles each, plus margin
	localparam int cycle_limit = 600;
	// strobe to done is two passes over the chain plus a few cycles
	localparam int wait_limit = 4 * `NODE_COUNT + 8;
	localparam int idle_check = 20;

	logic                       clk = 1'b0;
	logic                       reset;
	logic                       cmd_valid;
	center_sort_pkg::host_cmd_t cmd;
	center_sort_pkg::center_t   center_in;
	center_sort_pkg::axis_t     axis_in;
	logic                       busy;
	center_sort_pkg::center_t   center_out;
	logic                       center_out_valid;
	logic                       done;

	integer seed = 32'hf4d8;
	int     cycle_count = 0;
	int     checks = 0;
	int     value_errors = 0;
	int     other_errors = 0;

	// results of the most recent sort, in output order
	center_sort_pkg::center_t got[$];

	logic [8*32-1:0]          test_name;
	logic [8*8-1:0]           tag;
	logic [8*128-1:0]         line;
	int                       fd;
	int                       code;
	int                       n;
	int                       sel;
	center_sort_pkg::center_t value;

	center_sorter center_sorter_inst (
		.clk              (clk),
		.reset            (reset),
		.cmd_valid        (cmd_valid),
		.cmd              (cmd),
		.center_in        (center_in),
		.axis_in          (axis_in),
		.busy             (busy),
		.center_out       (center_out),
		.center_out_valid (center_out_valid),
		.done             (done)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycle_count);
			$display("checks: %0d, value errors: %0d, other errors: %0d",
				checks, value_errors, other_errors);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// inputs change 2 ns after the rising edge, outputs are read at that point too
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		checks++;
		assert (actual === expected) else begin
			$display("ERROR test %0s %0s: expected %0b, actual %0b",
				test_name, what, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_value(input int index, input center_sort_pkg::center_t expected,
		input center_sort_pkg::center_t actual);
		checks++;
		assert (actual === expected) else begin
			$display("ERROR test %0s output %0d: expected %h, actual %h",
				test_name, index, expected, actual);
			value_errors++;
		end
	endtask

	// one load strobe, then a random run of nop cycles with junk data
	task automatic load_center(input center_sort_pkg::center_t c);
		int gap;
		cmd_valid = 1'b1;
		cmd       = center_sort_pkg::cmd_load;
		center_in = c;
		next_cycle();
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) begin
			cmd       = center_sort_pkg::cmd_nop;
			center_in = center_sort_pkg::center_t'($random(seed));
			next_cycle();
		end
		cmd_valid = 1'b0;
		cmd       = center_sort_pkg::cmd_nop;
	endtask

	task automatic run_sort(input center_sort_pkg::axis_t a);
		int  waited;
		bit  done_seen;
		got.delete();
		cmd_valid = 1'b1;
		cmd       = center_sort_pkg::cmd_sort;
		axis_in   = a;
		next_cycle();
		check_bit("busy after sort strobe", 1'b1, busy);
		// a load and a sort during the exchange phases must be dropped
		cmd       = center_sort_pkg::cmd_load;
		center_in = center_sort_pkg::center_t'($random(seed));
		next_cycle();
		cmd     = center_sort_pkg::cmd_sort;
		axis_in = 2'd0;
		next_cycle();
		cmd_valid = 1'b0;
		cmd       = center_sort_pkg::cmd_nop;
		waited    = 0;
		done_seen = 1'b0;
		while (!done_seen && waited < wait_limit) begin
			next_cycle();
			waited++;
			if (center_out_valid) begin
				got.push_back(center_out);
				check_bit("done on last output", got.size() == `NODE_COUNT, done);
				check_bit("busy during output", got.size() != `NODE_COUNT, busy);
			end else begin
				checks++;
				assert (got.size() == 0 && !done) else begin
					$display("test %0s: result stream broke off or done came without data",
						test_name);
					other_errors++;
				end
			end
			if (done) begin
				done_seen = 1'b1;
			end
		end
		checks++;
		assert (done_seen) else begin
			$display("test %0s: sort did not finish within %0d cycles", test_name, wait_limit);
			other_errors++;
		end
	endtask

	// an illegal axis leaves the DUT idle
	task automatic ignored_sort(input center_sort_pkg::axis_t a);
		cmd_valid = 1'b1;
		cmd       = center_sort_pkg::cmd_sort;
		axis_in   = a;
		next_cycle();
		cmd_valid = 1'b0;
		cmd       = center_sort_pkg::cmd_nop;
		repeat (idle_check) begin
			check_bit("busy stays low", 1'b0, busy);
			check_bit("no output", 1'b0, center_out_valid);
			next_cycle();
		end
	endtask

	initial begin
		reset     = 1'b1;
		cmd_valid = 1'b0;
		cmd       = center_sort_pkg::cmd_nop;
		center_in = '0;
		axis_in   = '0;
		test_name = "reset";
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;

		check_bit("busy", 1'b0, busy);
		check_bit("center_out_valid", 1'b0, center_out_valid);
		check_bit("done", 1'b0, done);
		check_value(0, '0, center_out);

		fd = $fopen("verification/center_sorter_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file");
			other_errors++;
		end else begin
			code = 1;
			while (code == 1) begin
				code = $fscanf(fd, "%s", tag);
				if (code == 1) begin
					if (tag == "#") begin
						// rest of a comment line
						code = $fgets(line, fd);
						code = 1;
					end else if (tag == "L") begin
						code = $fscanf(fd, "%d", n);
						repeat (n) begin
							code = $fscanf(fd, "%h", value);
							load_center(value);
						end
						code = 1;
					end else if (tag == "S") begin
						code = $fscanf(fd, "%d %s", sel, test_name);
						if (sel == 3) begin
							ignored_sort(2'd3);
						end else begin
							run_sort(sel[1:0]);
						end
						code = 1;
					end else if (tag == "E") begin
						code = $fscanf(fd, "%d", n);
						checks++;
						assert (n == got.size()) else begin
							$display("test %0s: expected %0d outputs but saw %0d",
								test_name, n, got.size());
							other_errors++;
						end
						for (int i = 0; i < n; i++) begin
							code = $fscanf(fd, "%h", value);
							if (i < got.size()) begin
								check_value(i, value, got[i]);
							end
						end
						code = 1;
					end else begin
						$display("unknown record in the golden file");
						other_errors++;
					end
				end
			end
			$fclose(fd);
		end

		$display("checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
